/* vlog.f */
verilog/uart_pkg.sv
verilog/stream_pkg.sv
verilog/rx_byte_if.sv
verilog/uart_rx.sv
verilog/rx_merge.sv
verilog/dual_uart_rx.sv
bench/dual_uart_rx_checker.sv
bench/tb_dual_uart_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the dual UART receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_dual_uart_rx
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0

/* bench/tb_dual_uart_rx.sv */
`timescale 1ns/10ps

module tb_dual_uart_rx;

    localparam int CLKS_PER_BIT = uart_pkg::DEFAULT_CLKS_PER_BIT;
    localparam int SOLO_FRAMES  = 20;
    localparam int MIXED_FRAMES = 16;                   // Per channel
    localparam int TOTAL_FRAMES = 2 * SOLO_FRAMES + 4 * MIXED_FRAMES + 3;
    localparam longint WATCHDOG_NS = 2 * TOTAL_FRAMES * 10 * CLKS_PER_BIT * 10 + 20000;

    logic                                    clk;
    logic                                    reset_n;
    logic                                    rx_a;
    logic                                    rx_b;
    logic                                    out_valid;
    logic                                    out_ready;
    logic [uart_pkg::DATA_BITS-1:0]          out_data;
    logic [$bits(stream_pkg::channel_t)-1:0] out_channel;
    logic                                    out_frame_error;
    logic [stream_pkg::NUM_CHANNELS-1:0]     overrun;

    int seed;
    int check_errors;                                   // Counted by the stimulus process
    int monitor_errors;                                 // Counted by the output monitor
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    int received_a;
    int count_before;
    logic streams_done;

    // Bit 8 is the expected frame error, bits 7:0 the byte
    logic [8:0] model_a[$];
    logic [8:0] model_b[$];

    dual_uart_rx u_dual_uart_rx (
        .clk             (clk),
        .reset_n         (reset_n),
        .rx_a            (rx_a),
        .rx_b            (rx_b),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_data        (out_data),
        .out_channel     (out_channel),
        .out_frame_error (out_frame_error),
        .overrun         (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        rand_range = lo + int'($unsigned($random(seed)) % span);
    endfunction

    task automatic set_line(input int ch, input logic value);
        if (ch == 0) begin
            rx_a <= value;
        end else begin
            rx_b <= value;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        model_a.delete();
        model_b.delete();
    endtask

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop_bit,
                              input logic expected);
        logic [9:0] frame;
        int i;
        frame = {stop_bit, data, 1'b0};
        if (expected && ch == 0) begin
            model_a.push_back({~stop_bit, data});
        end else if (expected) begin
            model_b.push_back({~stop_bit, data});
        end
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            set_line(ch, frame[0]);
            frame = frame >> 1;
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic idle_gap(input int ch, input int bits);
        @(posedge clk);
        set_line(ch, 1'b1);
        repeat (bits * CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic stream_channel(input int ch, input int count, input int bad_pct,
                                  input int max_gap);
        logic [7:0] data;
        logic       stop;
        int n;
        for (n = 0; n < count; n++) begin
            idle_gap(ch, rand_range(1, max_gap));       // Random offset between channels
            data = 8'($random(seed));
            stop = rand_range(0, 99) >= bad_pct;
            send_frame(ch, data, stop, 1'b1);
        end
        idle_gap(ch, 1);
    endtask

    task automatic toggle_ready();
        while (!streams_done) begin
            @(posedge clk);
            out_ready <= ($random(seed) % 2) != 0;
        end
        @(posedge clk);
        out_ready <= 1'b1;
    endtask

    task automatic wait_drained();
        while (model_a.size() != 0 || model_b.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic check_overrun(input logic [1:0] expected);
        assert (overrun == expected) else begin
            $display("[ERROR] overrun: expected %h, actual %h", expected, overrun);
            check_errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = check_errors + monitor_errors;
    endtask

    task automatic finish_test(input string name);
        if (check_errors + monitor_errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
    endtask

    task automatic check_output(input logic [0:0] channel, input logic [7:0] data,
                                input logic frame_error);
        logic [8:0] expected;
        logic       found;
        found    = 1'b0;
        expected = '0;
        if (channel == stream_pkg::chan_a) begin
            received_a++;                               // Every channel A transfer
        end
        if (channel == stream_pkg::chan_a && model_a.size() != 0) begin
            expected = model_a.pop_front();
            found    = 1'b1;
        end else if (channel == stream_pkg::chan_b && model_b.size() != 0) begin
            expected = model_b.pop_front();
            found    = 1'b1;
        end
        assert (found) else begin
            $display("Byte %h came out on channel %0d but no byte was outstanding there",
                     data, channel);
            monitor_errors++;
        end
        if (found) begin
            assert (data == expected[7:0]) else begin
                $display("[ERROR] out_data: expected %h, actual %h", expected[7:0], data);
                monitor_errors++;
            end
            assert (frame_error == expected[8]) else begin
                $display("[ERROR] out_frame_error: expected %h, actual %h",
                         expected[8], frame_error);
                monitor_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset_n && out_valid && out_ready) begin
            check_output(out_channel, out_data, out_frame_error);
        end
    end

    initial begin
        reset_n      = 1'b0;
        rx_a         = 1'b1;
        rx_b         = 1'b1;
        out_ready    = 1'b0;
        seed         = 8141;
        streams_done = 1'b0;
        apply_reset();

        start_test();
        @(posedge clk);
        out_ready <= 1'b1;
        stream_channel(0, SOLO_FRAMES, 0, 4);
        wait_drained();
        finish_test("channel A alone");

        start_test();
        stream_channel(1, SOLO_FRAMES, 30, 4);          // About a third with low stop bits
        wait_drained();
        finish_test("channel B with bad stop bits");

        start_test();
        fork
            stream_channel(0, MIXED_FRAMES, 10, 3);
            stream_channel(1, MIXED_FRAMES, 10, 3);
        join
        wait_drained();
        finish_test("both channels");

        start_test();
        streams_done = 1'b0;
        fork
            begin
                fork
                    stream_channel(0, MIXED_FRAMES, 10, 3);
                    stream_channel(1, MIXED_FRAMES, 10, 3);
                join
                streams_done = 1'b1;
            end
            toggle_ready();
        join
        wait_drained();
        check_overrun(2'b00);
        finish_test("random back-pressure");

        start_test();
        @(posedge clk);
        out_ready <= 1'b0;
        count_before = received_a;
        send_frame(0, 8'($random(seed)), 1'b1, 1'b1); // Lands in the merge output register
        send_frame(0, 8'($random(seed)), 1'b1, 1'b1); // Waits in the receiver
        send_frame(0, 8'($random(seed)), 1'b1, 1'b0); // No room left, dropped
        idle_gap(0, 2);
        check_overrun(2'b01);
        @(posedge clk);
        out_ready <= 1'b1;
        wait_drained();
        repeat (12 * CLKS_PER_BIT) @(posedge clk);
        assert (received_a - count_before == 2) else begin
            $display("Channel A delivered %0d bytes after overrun, two were expected",
                     received_a - count_before);
            check_errors++;
        end
        check_overrun(2'b01);
        apply_reset();
        check_overrun(2'b00);
        finish_test("overrun");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && check_errors + monitor_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/dual_uart_rx_checker.sv */
`timescale 1ns/10ps

module dual_uart_rx_checker (
    input logic                                    clk,
    input logic                                    reset_n,
    input logic                                    out_valid,
    input logic                                    out_ready,
    input logic [uart_pkg::DATA_BITS-1:0]          out_data,
    input logic [$bits(stream_pkg::channel_t)-1:0] out_channel,
    input logic                                    out_frame_error,
    input logic [$bits(uart_pkg::rx_state_t)-1:0]  state_a,
    input logic [$bits(uart_pkg::rx_state_t)-1:0]  state_b
);

    logic state_a_legal;
    logic state_b_legal;

    assign state_a_legal = state_a inside {uart_pkg::idle, uart_pkg::start_half,
                                           uart_pkg::data_wait, uart_pkg::data_sample,
                                           uart_pkg::stop_wait};
    assign state_b_legal = state_b inside {uart_pkg::idle, uart_pkg::start_half,
                                           uart_pkg::data_wait, uart_pkg::data_sample,
                                           uart_pkg::stop_wait};

    // Output register clears on every reset cycle
    reset_clears_valid: assert property (@(posedge clk) !reset_n |=> !out_valid)
        else $error("out_valid was high after a reset cycle");

    hold_under_backpressure: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
                                    && $stable(out_channel) && $stable(out_frame_error))
        else $error("Output changed while out_valid was high and out_ready low");

    channel_known: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> !$isunknown(out_channel))
        else $error("out_channel unknown while out_valid was high");

    receiver_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state_a_legal && state_b_legal)
        else $error("Receiver state outside the state enum");

endmodule

bind dual_uart_rx dual_uart_rx_checker u_checker (
    .clk             (clk),
    .reset_n         (reset_n),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .out_channel     (out_channel),
    .out_frame_error (out_frame_error),
    .state_a         (u_rx_a.state),
    .state_b         (u_rx_b.state)
);

/* verilog/dual_uart_rx.sv */
`timescale 1ns/10ps

module dual_uart_rx #(
    parameter int CLKS_PER_BIT = uart_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      rx_a,
    input  logic                                      rx_b,
    output logic                                      out_valid,
    input  logic                                      out_ready,
    output logic [uart_pkg::DATA_BITS-1:0]            out_data,
    output logic [$bits(stream_pkg::channel_t)-1:0]   out_channel,
    output logic                                      out_frame_error,
    output logic [stream_pkg::NUM_CHANNELS-1:0]       overrun     // Bit 0 is channel A
);

    rx_byte_if rx_a_bus ();
    rx_byte_if rx_b_bus ();

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx_a (
        .clk     (clk),
        .reset_n (reset_n),
        .rx      (rx_a),
        .rx_bus  (rx_a_bus),
        .overrun (overrun[0])
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx_b (
        .clk     (clk),
        .reset_n (reset_n),
        .rx      (rx_b),
        .rx_bus  (rx_b_bus),
        .overrun (overrun[1])
    );

    rx_merge u_merge (
        .clk             (clk),
        .reset_n         (reset_n),
        .in_a            (rx_a_bus),
        .in_b            (rx_b_bus),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_data        (out_data),
        .out_channel     (out_channel),
        .out_frame_error (out_frame_error)
    );

endmodule

/* verilog/rx_merge.sv */
`timescale 1ns/10ps

module rx_merge (
    input  logic                           clk,
    input  logic                           reset_n,
    rx_byte_if.sink                        in_a,
    rx_byte_if.sink                        in_b,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [uart_pkg::DATA_BITS-1:0] out_data,
    output stream_pkg::channel_t           out_channel,
    output logic                           out_frame_error
);

    stream_pkg::channel_t last_grant;
    stream_pkg::channel_t grant;
    logic                 grant_valid;
    logic                 load;

    assign load        = !out_valid || out_ready;       // Output empty or draining
    assign grant_valid = in_a.valid || in_b.valid;

    always_comb begin
        grant = stream_pkg::chan_a;
        if (in_a.valid && in_b.valid) begin
            // Contention goes to the channel that lost last time
            grant = (last_grant == stream_pkg::chan_a) ? stream_pkg::chan_b
                                                       : stream_pkg::chan_a;
        end else if (in_b.valid) begin
            grant = stream_pkg::chan_b;
        end
    end

    assign in_a.ready = load && (grant == stream_pkg::chan_a);
    assign in_b.ready = load && (grant == stream_pkg::chan_b);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid  <= 1'b0;
            last_grant <= stream_pkg::chan_b;           // Channel A first after reset
        end else if (load) begin
            out_valid <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && grant_valid) begin
            out_channel <= grant;
            if (grant == stream_pkg::chan_b) begin
                out_data        <= in_b.data;
                out_frame_error <= in_b.frame_error;
            end else begin
                out_data        <= in_a.data;
                out_frame_error <= in_a.frame_error;
            end
        end
    end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = uart_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      rx,
    rx_byte_if.source rx_bus,
    output logic      overrun
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS + 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(CLKS_PER_BIT - 2);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] ALL_BITS = BIT_W'(uart_pkg::DATA_BITS);

    uart_pkg::rx_state_t state, state_next;
    logic [CNT_W-1:0] clk_cnt, clk_cnt_next;
    logic [BIT_W-1:0] bit_cnt, bit_cnt_next;
    logic [uart_pkg::DATA_BITS-1:0] shift_reg, shift_next;

    logic rx_meta;
    logic rx_sync;
    logic stop_sample;                                  // Stop bit centre this cycle

    logic                           hold_valid;
    logic [uart_pkg::DATA_BITS-1:0] hold_data;
    logic                           hold_frame_error;
    logic                           hold_free;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;                            // Idle line level
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state   <= uart_pkg::idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            state   <= state_next;
            clk_cnt <= clk_cnt_next;
            bit_cnt <= bit_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= shift_next;
    end

    always_comb begin
        state_next   = state;
        clk_cnt_next = clk_cnt;
        bit_cnt_next = bit_cnt;
        shift_next   = shift_reg;
        stop_sample  = 1'b0;

        case (state)
            uart_pkg::idle: begin
                clk_cnt_next = '0;
                bit_cnt_next = '0;
                if (!rx_sync) begin
                    state_next = uart_pkg::start_half;
                end
            end

            uart_pkg::start_half: begin
                clk_cnt_next = clk_cnt + 1'b1;
                if (clk_cnt == HALF_CNT) begin
                    clk_cnt_next = '0;
                    // High at the centre means a glitch, not a start bit
                    state_next = rx_sync ? uart_pkg::idle : uart_pkg::data_wait;
                end
            end

            uart_pkg::data_wait: begin
                clk_cnt_next = clk_cnt + 1'b1;
                if (clk_cnt == WAIT_CNT) begin            // Sample state adds the last clock
                    clk_cnt_next = '0;
                    state_next   = uart_pkg::data_sample;
                end
            end

            uart_pkg::data_sample: begin
                shift_next   = {rx_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};   // LSB first
                bit_cnt_next = bit_cnt + 1'b1;
                state_next   = (bit_cnt == ALL_BITS - 1'b1) ? uart_pkg::stop_wait
                                                           : uart_pkg::data_wait;
            end

            uart_pkg::stop_wait: begin
                if (bit_cnt == ALL_BITS) begin
                    clk_cnt_next = clk_cnt + 1'b1;
                    if (clk_cnt == LAST_CNT) begin
                        stop_sample  = 1'b1;
                        clk_cnt_next = '0;
                        bit_cnt_next = '0;
                        state_next   = rx_sync ? uart_pkg::idle : uart_pkg::stop_wait;
                    end
                end else if (rx_sync) begin
                    state_next = uart_pkg::idle;         // Line released after a low stop bit
                end
            end

            default: begin
                state_next = uart_pkg::idle;
            end
        endcase
    end

    assign hold_free = !hold_valid || rx_bus.ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            hold_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            if (stop_sample && hold_free) begin
                hold_valid <= 1'b1;
            end else if (rx_bus.ready) begin
                hold_valid <= 1'b0;
            end
            if (stop_sample && !hold_free) begin
                overrun <= 1'b1;                        // New byte dropped, sticky
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stop_sample && hold_free) begin
            hold_data        <= shift_reg;
            hold_frame_error <= ~rx_sync;
        end
    end

    assign rx_bus.valid       = hold_valid;
    assign rx_bus.data        = hold_data;
    assign rx_bus.frame_error = hold_frame_error;

endmodule

/* verilog/rx_byte_if.sv */
`timescale 1ns/10ps

interface rx_byte_if;

    logic                           valid;
    logic                           ready;
    logic [uart_pkg::DATA_BITS-1:0] data;
    logic                           frame_error;    // Stop bit was low

    modport source (
        output valid,
        output data,
        output frame_error,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  frame_error,
        output ready
    );

endinterface

/* verilog/stream_pkg.sv */
package stream_pkg;

    localparam int NUM_CHANNELS = 2;

    // Tag carried with each merged byte
    typedef enum logic {
        chan_a = 1'b0,
        chan_b = 1'b1
    } channel_t;

endpackage

/* verilog/uart_pkg.sv */
package uart_pkg;

    // Frame format is fixed at 8N1
    localparam int DATA_BITS = 8;

    // Short bit period keeps simulation fast
    localparam int DEFAULT_CLKS_PER_BIT = 16;

    typedef enum logic [2:0] {
        idle,           // Line high, waiting for a start bit
        start_half,     // Moving to the centre of the start bit
        data_wait,      // Counting one bit period
        data_sample,    // Capturing one data bit
        stop_wait       // Counting to the stop bit centre
    } rx_state_t;

endpackage
